/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_floor_logic
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only if the log holds the pass message
run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
elevator_pkg.sv
car_input_stage.sv
floor_request_cell.sv
target_selector.sv
floor_logic_top.sv
tb_floor_logic.sv

/* car_input_stage.sv */
module car_input_stage
    import elevator_pkg::*;
(
    input  logic                           clock,
    input  logic                           reset_n,

    // Raw buttons
    input  floor_mask_t                    floor_call_buttons,
    input  floor_mask_t                    panel_buttons,
    input  logic                           door_open_btn,
    input  logic                           door_close_btn,
    input  logic                           emergency_btn,
    input  logic                           power_switch,

    // Car position and motion
    input  floor_t                         current_floor,
    input  logic                           elevator_moving,
    input  logic                           elevator_direction,

    output car_status_t                    status,
    output floor_press_t [num_floors-1:0]  press,
    output logic                           door_open_allowed,
    output logic                           door_close_allowed
);

    floor_mask_t call_q;
    floor_mask_t panel_q;

    //////////////////////////////////////////////////////////////////////
    // Button and status registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_q  <= '0;
            panel_q <= '0;
        end else begin
            call_q  <= floor_call_buttons;
            panel_q <= panel_buttons;
        end
    end

    // Service enable is formed here once and shared downstream
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            status <= '0;
        end else begin
            status.floor          <= current_floor;
            status.moving         <= elevator_moving;
            status.direction_up   <= elevator_direction;
            status.service_enable <= power_switch && !emergency_btn;
        end
    end

    // Regroup the two masks into one press struct per floor
    always_comb begin
        for (int f = 0; f < num_floors; f++) begin
            press[f].call_press  = call_q[f];
            press[f].panel_press = panel_q[f];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Door permits
    //////////////////////////////////////////////////////////////////////

    // Only a stopped, powered car may move its doors
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            door_open_allowed  <= 1'b0;
            door_close_allowed <= 1'b0;
        end else begin
            door_open_allowed  <= door_open_btn && !elevator_moving && power_switch;
            door_close_allowed <= door_close_btn && !elevator_moving && power_switch;
        end
    end

endmodule

/* elevator_pkg.sv */
package elevator_pkg;

    //////////////////////////////////////////////////////////////////////
    // Building size
    //////////////////////////////////////////////////////////////////////

    // Floors served by the car, numbered 0 (lowest) upward
    localparam int num_floors = 11;

    // Enough bits to hold any floor number
    localparam int floor_width = 4;

    typedef logic [floor_width-1:0] floor_t;

    // One bit per floor, bit 0 is the lowest floor
    typedef logic [num_floors-1:0] floor_mask_t;

    //////////////////////////////////////////////////////////////////////
    // Shared structures
    //////////////////////////////////////////////////////////////////////

    // Registered view of the car, seen by every cell and the selector
    typedef struct packed {
        floor_t floor;
        logic   moving;
        logic   direction_up;
        // Power on and emergency not pressed
        logic   service_enable;
    } car_status_t;

    // Button presses of a single floor
    typedef struct packed {
        logic call_press;
        logic panel_press;
    } floor_press_t;

    // Request lights of a single floor
    typedef struct packed {
        logic call_light;
        logic panel_light;
    } floor_light_t;

endpackage

/* floor_logic_top.sv */
module floor_logic_top
    import elevator_pkg::*;
(
    input  logic        clock,
    input  logic        reset_n,

    input  floor_mask_t floor_call_buttons,
    input  floor_mask_t panel_buttons,
    input  logic        door_open_btn,
    input  logic        door_close_btn,
    input  logic        emergency_btn,
    input  logic        power_switch,
    input  floor_t      current_floor,
    input  logic        elevator_moving,
    input  logic        elevator_direction,

    output floor_mask_t call_button_lights,
    output floor_mask_t panel_button_lights,
    output floor_t      target_floor,
    output logic        direction_select,
    output logic        activate_elevator,
    output logic        door_open_allowed,
    output logic        door_close_allowed
);

    car_status_t                   status;
    floor_press_t [num_floors-1:0] press;
    floor_light_t [num_floors-1:0] light;

    car_input_stage u_car_input_stage (
        .clock              (clock),
        .reset_n            (reset_n),
        .floor_call_buttons (floor_call_buttons),
        .panel_buttons      (panel_buttons),
        .door_open_btn      (door_open_btn),
        .door_close_btn     (door_close_btn),
        .emergency_btn      (emergency_btn),
        .power_switch       (power_switch),
        .current_floor      (current_floor),
        .elevator_moving    (elevator_moving),
        .elevator_direction (elevator_direction),
        .status             (status),
        .press              (press),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

    // One request cell per floor
    for (genvar i = 0; i < num_floors; i++) begin : g_floor
        floor_request_cell #(
            .floor_index (floor_t'(i))
        ) u_floor_request_cell (
            .clock   (clock),
            .reset_n (reset_n),
            .status  (status),
            .press   (press[i]),
            .light   (light[i])
        );

        assign call_button_lights[i]  = light[i].call_light;
        assign panel_button_lights[i] = light[i].panel_light;
    end

    target_selector u_target_selector (
        .clock             (clock),
        .reset_n           (reset_n),
        .status            (status),
        .light             (light),
        .target_floor      (target_floor),
        .direction_select  (direction_select),
        .activate_elevator (activate_elevator)
    );

endmodule

/* floor_request_cell.sv */
module floor_request_cell
    import elevator_pkg::*;
#(
    parameter floor_t floor_index = '0
) (
    input  logic         clock,
    input  logic         reset_n,
    input  car_status_t  status,
    input  floor_press_t press,
    output floor_light_t light
);

    logic at_floor;
    logic stopped_here;

    assign at_floor     = (status.floor == floor_index);
    assign stopped_here = at_floor && !status.moving;

    //////////////////////////////////////////////////////////////////////
    // Request lights
    //////////////////////////////////////////////////////////////////////

    // Lights freeze while service is off
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            light <= '0;
        end else if (status.service_enable) begin
            if (stopped_here) begin
                // Car is serving this floor, drop both requests
                light <= '0;
            end else if (!at_floor) begin
                if (press.call_press) begin
                    light.call_light <= 1'b1;
                end
                if (press.panel_press) begin
                    light.panel_light <= 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // A press at the car's own floor is never latched
    assert property (@(posedge clock) disable iff (!reset_n)
        at_floor |=> !$rose(light.call_light) && !$rose(light.panel_light))
    else $error("floor %0d: light rose while car at this floor", floor_index);

endmodule

/* target_selector.sv */
module target_selector
    import elevator_pkg::*;
(
    input  logic                           clock,
    input  logic                           reset_n,
    input  car_status_t                    status,
    input  floor_light_t [num_floors-1:0]  light,
    output floor_t                         target_floor,
    output logic                           direction_select,
    output logic                           activate_elevator
);

    floor_mask_t pending;
    logic        found_above;
    logic        found_below;
    floor_t      nearest_above;
    floor_t      nearest_below;
    floor_t      next_floor;
    logic        load_target;
    logic        direction_q;

    // A floor is pending if either of its lights is on
    always_comb begin
        for (int f = 0; f < num_floors; f++) begin
            pending[f] = light[f].call_light || light[f].panel_light;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Nearest pending floor on each side of the car
    //////////////////////////////////////////////////////////////////////

    // Scan downward so the last hit is the lowest floor above the car
    always_comb begin
        found_above   = 1'b0;
        nearest_above = status.floor;
        for (int f = num_floors - 1; f >= 0; f--) begin
            if (pending[f] && (floor_t'(f) > status.floor)) begin
                found_above   = 1'b1;
                nearest_above = floor_t'(f);
            end
        end
    end

    // Scan upward so the last hit is the highest floor below the car
    always_comb begin
        found_below   = 1'b0;
        nearest_below = status.floor;
        for (int f = 0; f < num_floors; f++) begin
            if (pending[f] && (floor_t'(f) < status.floor)) begin
                found_below   = 1'b1;
                nearest_below = floor_t'(f);
            end
        end
    end

    // Current direction of travel is tried first
    always_comb begin
        next_floor = status.floor;
        if (status.direction_up) begin
            if (found_above) begin
                next_floor = nearest_above;
            end else if (found_below) begin
                next_floor = nearest_below;
            end
        end else begin
            if (found_below) begin
                next_floor = nearest_below;
            end else if (found_above) begin
                next_floor = nearest_above;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Target register
    //////////////////////////////////////////////////////////////////////

    // A new choice is taken only once the old target has been reached
    assign load_target = !status.moving && (target_floor == status.floor);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            target_floor <= '0;
        end else if (load_target) begin
            target_floor <= next_floor;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Drive toward the target
    //////////////////////////////////////////////////////////////////////

    assign activate_elevator = status.service_enable && !status.moving &&
                               (target_floor != status.floor);

    // Direction holds its last value when target and car agree
    always_comb begin
        if (target_floor > status.floor) begin
            direction_select = 1'b1;
        end else if (target_floor < status.floor) begin
            direction_select = 1'b0;
        end else begin
            direction_select = direction_q;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            direction_q <= 1'b1;
        end else begin
            direction_q <= direction_select;
        end
    end

    // Checks
    assert property (@(posedge clock) disable iff (!reset_n)
        target_floor < floor_t'(num_floors))
    else $error("target_floor %0d out of range", target_floor);

    assert property (@(posedge clock) disable iff (!reset_n)
        activate_elevator |-> (target_floor != status.floor))
    else $error("activate with target equal to car floor %0d", status.floor);

endmodule

/* tb_floor_logic.sv */
module tb_floor_logic
    import elevator_pkg::*;
();

    localparam int press_cycles   = 40;
    localparam int frozen_cycles  = 30;
    localparam int trip_count     = 20;
    localparam int trip_cycles    = 5;
    localparam int door_cycles    = 20;
    localparam int drain_cycles   = 4;
    localparam int planned_cycles = 3 + press_cycles + frozen_cycles +
                                    trip_count * trip_cycles + door_cycles + drain_cycles;
    localparam int cycle_limit    = planned_cycles * 3 / 2;

    logic        clock;
    logic        reset_n;
    floor_mask_t floor_call_buttons;
    floor_mask_t panel_buttons;
    logic        door_open_btn;
    logic        door_close_btn;
    logic        emergency_btn;
    logic        power_switch;
    floor_t      current_floor;
    logic        elevator_moving;
    logic        elevator_direction;
    floor_mask_t call_button_lights;
    floor_mask_t panel_button_lights;
    floor_t      target_floor;
    logic        direction_select;
    logic        activate_elevator;
    logic        door_open_allowed;
    logic        door_close_allowed;

    // Reference model state
    floor_mask_t m_call_q;
    floor_mask_t m_panel_q;
    car_status_t m_status;
    floor_mask_t m_call_light;
    floor_mask_t m_panel_light;
    floor_t      m_target;
    logic        m_dir_q;
    logic        m_door_open;
    logic        m_door_close;
    logic        exp_activate;
    logic        exp_direction;

    int          light_errors  = 0;
    int          target_errors = 0;
    int          drive_errors  = 0;
    int          door_errors   = 0;
    int          reset_errors  = 0;
    int          cycle_count   = 0;
    int unsigned seed;

    floor_logic_top u_floor_logic_top (
        .clock               (clock),
        .reset_n             (reset_n),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .door_open_btn       (door_open_btn),
        .door_close_btn      (door_close_btn),
        .emergency_btn       (emergency_btn),
        .power_switch        (power_switch),
        .current_floor       (current_floor),
        .elevator_moving     (elevator_moving),
        .elevator_direction  (elevator_direction),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights),
        .target_floor        (target_floor),
        .direction_select    (direction_select),
        .activate_elevator   (activate_elevator),
        .door_open_allowed   (door_open_allowed),
        .door_close_allowed  (door_close_allowed)
    );

    initial clock = 1'b0;
    always #2 clock = ~clock;

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    // Presses away from the car set lights and a stop clears its own floor
    function automatic floor_mask_t next_lights(floor_mask_t lights, floor_mask_t presses,
                                                car_status_t st);
        floor_mask_t here;
        here = floor_mask_t'(1) << st.floor;
        if (!st.service_enable) begin
            return lights;
        end
        if (st.moving) begin
            return lights | (presses & ~here);
        end
        return (lights | presses) & ~here;
    endfunction

    // Walk outward from the car with the preferred side first
    function automatic floor_t pick_target(floor_mask_t pend, floor_t cur, logic up);
        floor_t best;
        logic   done;
        logic   going_up;
        int     cand;
        best = cur;
        done = 1'b0;
        for (int pass = 0; pass < 2; pass++) begin
            going_up = (pass == 0) ? up : !up;
            for (int d = 1; d < num_floors; d++) begin
                cand = going_up ? int'(cur) + d : int'(cur) - d;
                if (!done && cand >= 0 && cand < num_floors) begin
                    if (pend[cand[floor_width-1:0]]) begin
                        best = floor_t'(cand);
                        done = 1'b1;
                    end
                end
            end
        end
        return best;
    endfunction

    function automatic floor_mask_t sparse_mask();
        return floor_mask_t'($urandom & $urandom & $urandom & $urandom);
    endfunction

    always @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            m_call_q      <= '0;
            m_panel_q     <= '0;
            m_status      <= '0;
            m_call_light  <= '0;
            m_panel_light <= '0;
            m_target      <= '0;
            m_dir_q       <= 1'b1;
            m_door_open   <= 1'b0;
            m_door_close  <= 1'b0;
        end else begin
            m_call_q                <= floor_call_buttons;
            m_panel_q               <= panel_buttons;
            m_status.floor          <= current_floor;
            m_status.moving         <= elevator_moving;
            m_status.direction_up   <= elevator_direction;
            m_status.service_enable <= power_switch && !emergency_btn;
            m_call_light            <= next_lights(m_call_light, m_call_q, m_status);
            m_panel_light           <= next_lights(m_panel_light, m_panel_q, m_status);
            if (!m_status.moving && (m_target == m_status.floor)) begin
                m_target <= pick_target(m_call_light | m_panel_light, m_status.floor,
                                        m_status.direction_up);
            end
            m_dir_q      <= exp_direction;
            m_door_open  <= (elevator_moving || !power_switch) ? 1'b0 : door_open_btn;
            m_door_close <= (elevator_moving || !power_switch) ? 1'b0 : door_close_btn;
        end
    end

    assign exp_activate = m_status.service_enable && !m_status.moving &&
                          (m_target != m_status.floor);

    always_comb begin
        if (m_target == m_status.floor) begin
            exp_direction = m_dir_q;
        end else begin
            exp_direction = (m_target > m_status.floor);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    assert property (@(posedge clock) $rose(reset_n) |->
        (call_button_lights == '0) && (panel_button_lights == '0) && !activate_elevator &&
        !door_open_allowed && !door_close_allowed && direction_select && (target_floor == '0))
    else begin
        reset_errors++;
        $display("Outputs were not at their reset values when reset was released");
    end

    assert property (@(posedge clock) disable iff (!reset_n) call_button_lights == m_call_light)
    else begin
        light_errors++;
        $display("ERROR t=%0t call_button_lights expected %h actual %h", $time,
                 $sampled(m_call_light), $sampled(call_button_lights));
    end

    assert property (@(posedge clock) disable iff (!reset_n) panel_button_lights == m_panel_light)
    else begin
        light_errors++;
        $display("ERROR t=%0t panel_button_lights expected %h actual %h", $time,
                 $sampled(m_panel_light), $sampled(panel_button_lights));
    end

    assert property (@(posedge clock) disable iff (!reset_n) target_floor == m_target)
    else begin
        target_errors++;
        $display("ERROR t=%0t target_floor expected %0d actual %0d", $time,
                 $sampled(m_target), $sampled(target_floor));
    end

    assert property (@(posedge clock) disable iff (!reset_n) activate_elevator == exp_activate)
    else begin
        drive_errors++;
        $display("ERROR t=%0t activate_elevator expected %b actual %b", $time,
                 $sampled(exp_activate), $sampled(activate_elevator));
    end

    assert property (@(posedge clock) disable iff (!reset_n) direction_select == exp_direction)
    else begin
        drive_errors++;
        $display("ERROR t=%0t direction_select expected %b actual %b", $time,
                 $sampled(exp_direction), $sampled(direction_select));
    end

    assert property (@(posedge clock) disable iff (!reset_n) door_open_allowed == m_door_open)
    else begin
        door_errors++;
        $display("ERROR t=%0t door_open_allowed expected %b actual %b", $time,
                 $sampled(m_door_open), $sampled(door_open_allowed));
    end

    assert property (@(posedge clock) disable iff (!reset_n) door_close_allowed == m_door_close)
    else begin
        door_errors++;
        $display("ERROR t=%0t door_close_allowed expected %b actual %b", $time,
                 $sampled(m_door_close), $sampled(door_close_allowed));
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, the stimulus did not finish", cycle_count);
            $display("Done: errors found");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic apply_idle_inputs();
        floor_call_buttons = '0;
        panel_buttons      = '0;
        door_open_btn      = 1'b0;
        door_close_btn     = 1'b0;
        emergency_btn      = 1'b0;
        power_switch       = 1'b1;
        elevator_moving    = 1'b0;
        elevator_direction = 1'b1;
    endtask

    // Car passes random floors while buttons are pressed
    task automatic latch_random_presses();
        floor_t here;
        for (int i = 0; i < press_cycles; i++) begin
            @(negedge clock);
            here               = floor_t'($urandom_range(0, num_floors - 1));
            current_floor      = here;
            elevator_moving    = 1'b1;
            elevator_direction = 1'($urandom_range(0, 1));
            floor_call_buttons = sparse_mask();
            panel_buttons      = sparse_mask();
            // Now and then press the floor the car is passing
            if ($urandom_range(0, 3) == 0) begin
                floor_call_buttons = floor_call_buttons | (floor_mask_t'(1) << here);
                panel_buttons      = panel_buttons | (floor_mask_t'(1) << here);
            end
            door_open_btn = 1'($urandom_range(0, 1));
        end
    endtask

    // Power off or emergency while the car stands
    task automatic hold_service_off();
        for (int i = 0; i < frozen_cycles; i++) begin
            @(negedge clock);
            power_switch       = 1'($urandom_range(0, 1));
            emergency_btn      = power_switch ? 1'b1 : 1'($urandom_range(0, 1));
            elevator_moving    = 1'b0;
            current_floor      = floor_t'($urandom_range(0, num_floors - 1));
            floor_call_buttons = sparse_mask();
            panel_buttons      = sparse_mask();
            door_open_btn      = 1'($urandom_range(0, 1));
            door_close_btn     = 1'($urandom_range(0, 1));
        end
        apply_idle_inputs();
    endtask

    // Each trip moves the car and then stops it at the expected target
    task automatic stop_at_targets();
        for (int t = 0; t < trip_count; t++) begin
            @(negedge clock);
            elevator_moving    = 1'b1;
            current_floor      = floor_t'($urandom_range(0, num_floors - 1));
            elevator_direction = 1'($urandom_range(0, 1));
            floor_call_buttons = sparse_mask();
            panel_buttons      = sparse_mask();
            @(negedge clock);
            floor_call_buttons = '0;
            panel_buttons      = '0;
            @(negedge clock);
            elevator_moving = 1'b0;
            current_floor   = m_target;
            repeat (trip_cycles - 3) @(negedge clock);
        end
    endtask

    task automatic toggle_door_buttons();
        for (int i = 0; i < door_cycles; i++) begin
            @(negedge clock);
            power_switch    = 1'($urandom_range(0, 1));
            elevator_moving = 1'($urandom_range(0, 1));
            door_open_btn   = 1'($urandom_range(0, 1));
            door_close_btn  = 1'($urandom_range(0, 1));
        end
        apply_idle_inputs();
    endtask

    initial begin
        int total;
        seed = 32'hd638_820f;
        void'($urandom(seed));
        reset_n       = 1'b0;
        current_floor = '0;
        apply_idle_inputs();
        repeat (3) @(negedge clock);
        reset_n = 1'b1;

        latch_random_presses();
        hold_service_off();
        stop_at_targets();
        toggle_door_buttons();
        repeat (drain_cycles) @(negedge clock);

        total = light_errors + target_errors + drive_errors + door_errors + reset_errors;
        $display("Error counts: lights %0d, target %0d, drive %0d, doors %0d, reset %0d",
                 light_errors, target_errors, drive_errors, door_errors, reset_errors);
        if (total == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
